// File: hdl/udp_host_pkg.sv
// UDP host controller definitions
`default_nettype none

package udp_host_pkg;

  // Field widths with a meaning of their own
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [15:0] udp_len_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [4:0]  fifo_cnt_t;

  // Outbound datagram sequencing
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HDR,
    TX_DATA
  } tx_state_t;

  localparam int       FIFO_DEPTH    = 16;
  localparam udp_len_t UDP_HDR_BYTES = 16'd8;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // CSR byte offsets
  localparam axil_addr_t REG_LOCAL_IP   = 8'h00;
  localparam axil_addr_t REG_SEND_IP    = 8'h04;
  localparam axil_addr_t REG_SEND_PORTS = 8'h08;
  localparam axil_addr_t REG_SEND_LEN   = 8'h0C;
  localparam axil_addr_t REG_CTRL       = 8'h10;
  localparam axil_addr_t REG_STATUS     = 8'h14;
  localparam axil_addr_t REG_TX_DATA    = 8'h18;
  localparam axil_addr_t REG_RX_DATA    = 8'h1C;
  localparam axil_addr_t REG_RECV_IP    = 8'h20;
  localparam axil_addr_t REG_RECV_PORTS = 8'h24;
  localparam axil_addr_t REG_RECV_LEN   = 8'h28;

  // REG_CTRL command bits
  localparam int CTRL_SEND      = 0;
  localparam int CTRL_CLEAR_IRQ = 1;
  localparam int CTRL_TXF_CLEAR = 2;
  localparam int CTRL_RXF_CLEAR = 3;

endpackage

`default_nettype wire

// File: hdl/pkt_fifo.sv
// Show-ahead packet byte FIFO
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo #(
  parameter int DEPTH = udp_host_pkg::FIFO_DEPTH
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      i_clear,
  input  wire                      i_push,
  input  wire udp_host_pkg::byte_t i_data,
  input  wire                      i_pop,
  output udp_host_pkg::byte_t      o_data,
  output logic                     o_empty,
  output logic                     o_full,
  output udp_host_pkg::fifo_cnt_t  o_count
);
  import udp_host_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  byte_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_cnt_t        count;
  logic             do_push;
  logic             do_pop;

  assign o_empty = (count == '0);
  assign o_full  = (count == fifo_cnt_t'(DEPTH));
  assign o_count = count;
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  // Head of the queue is always visible
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/udp_pkt_ctrl.sv
// Datagram send and receive control
`timescale 1ns/1ps
`default_nettype none

module udp_pkt_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         i_send,
  input  wire                         i_clear_irq,
  input  wire udp_host_pkg::udp_len_t i_send_len,
  output logic                        o_tx_hdr_valid,
  output udp_host_pkg::udp_len_t      o_tx_udp_length,
  output logic                        o_tx_tvalid,
  output logic                        o_tx_tlast,
  output logic                        o_txf_pop,
  output logic                        o_tx_busy,
  input  wire                         i_tx_hdr_ready,
  input  wire                         i_txf_empty,
  input  wire                         i_tx_tready,
  input  wire                         i_rx_hdr_valid,
  input  wire udp_host_pkg::ip_addr_t  i_rx_src_ip,
  input  wire udp_host_pkg::udp_port_t i_rx_src_port,
  input  wire udp_host_pkg::udp_port_t i_rx_dst_port,
  input  wire udp_host_pkg::udp_len_t  i_rx_udp_length,
  input  wire                         i_rx_tvalid,
  input  wire                         i_rx_tready,
  input  wire                         i_rx_tlast,
  output udp_host_pkg::ip_addr_t      o_recv_ip,
  output udp_host_pkg::udp_port_t     o_recv_src_port,
  output udp_host_pkg::udp_port_t     o_recv_dst_port,
  output udp_host_pkg::udp_len_t      o_recv_len,
  output logic                        o_irq_rx,
  output logic                        o_irq_tx
);
  import udp_host_pkg::*;

  tx_state_t state;
  udp_len_t  len_q;
  udp_len_t  byte_cnt;
  logic      tx_fire;
  logic      tx_done;
  logic      rx_done;

  assign o_tx_hdr_valid  = (state == TX_HDR);
  assign o_tx_tvalid     = (state == TX_DATA) && !i_txf_empty;
  assign o_tx_tlast      = (state == TX_DATA) && (byte_cnt == len_q - udp_len_t'(1));
  assign o_tx_busy       = (state != TX_IDLE);
  assign o_tx_udp_length = len_q + UDP_HDR_BYTES;
  assign tx_fire         = o_tx_tvalid && i_tx_tready;
  assign o_txf_pop       = tx_fire;
  assign tx_done         = tx_fire && o_tx_tlast;
  assign rx_done         = i_rx_tvalid && i_rx_tready && i_rx_tlast;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      byte_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: if (i_send) begin
          state    <= TX_HDR;
          byte_cnt <= '0;
        end
        TX_HDR: if (i_tx_hdr_ready) begin
          state <= TX_DATA;
        end
        TX_DATA: if (tx_fire) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (o_tx_tlast) state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Length is frozen for the whole datagram
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && i_send) begin
      len_q <= i_send_len;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rx_hdr_valid) begin
      o_recv_ip       <= i_rx_src_ip;
      o_recv_src_port <= i_rx_src_port;
      o_recv_dst_port <= i_rx_dst_port;
      o_recv_len      <= i_rx_udp_length;
    end
  end

  // Clear wins over a set in the same cycle
  always_ff @(posedge clk) begin
    if (rst || i_clear_irq) begin
      o_irq_rx <= 1'b0;
      o_irq_tx <= 1'b0;
    end else begin
      if (rx_done) o_irq_rx <= 1'b1;
      if (tx_done) o_irq_tx <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/udp_csr.sv
// AXI4-Lite register block
`timescale 1ns/1ps
`default_nettype none

module udp_csr (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           i_awvalid,
  input  wire udp_host_pkg::axil_addr_t i_awaddr,
  output logic                          o_awready,
  input  wire                           i_wvalid,
  input  wire udp_host_pkg::axil_data_t i_wdata,
  output logic                          o_wready,
  output logic                          o_bvalid,
  output udp_host_pkg::axil_resp_t      o_bresp,
  input  wire                           i_bready,
  input  wire                           i_arvalid,
  input  wire udp_host_pkg::axil_addr_t i_araddr,
  output logic                          o_arready,
  output logic                          o_rvalid,
  output udp_host_pkg::axil_data_t      o_rdata,
  output udp_host_pkg::axil_resp_t      o_rresp,
  input  wire                           i_rready,
  input  wire                           i_rx_irq,
  input  wire                           i_tx_irq,
  input  wire                           i_tx_busy,
  input  wire                           i_txf_empty,
  input  wire                           i_txf_full,
  input  wire                           i_rxf_empty,
  input  wire                           i_rxf_full,
  input  wire udp_host_pkg::byte_t      i_rxf_data,
  input  wire udp_host_pkg::ip_addr_t   i_recv_ip,
  input  wire udp_host_pkg::udp_port_t  i_recv_src_port,
  input  wire udp_host_pkg::udp_port_t  i_recv_dst_port,
  input  wire udp_host_pkg::udp_len_t   i_recv_len,
  output udp_host_pkg::ip_addr_t        o_local_ip,
  output udp_host_pkg::ip_addr_t        o_send_ip,
  output udp_host_pkg::udp_port_t       o_send_src_port,
  output udp_host_pkg::udp_port_t       o_send_dst_port,
  output udp_host_pkg::udp_len_t        o_send_len,
  output logic                          o_send,
  output logic                          o_clear_irq,
  output logic                          o_txf_clear,
  output logic                          o_rxf_clear,
  output logic                          o_txf_push,
  output logic                          o_rxf_pop,
  output udp_host_pkg::byte_t           o_txf_data
);
  import udp_host_pkg::*;

  logic       wr_fire;
  logic       rd_fire;
  logic       ctrl_wr;
  axil_resp_t wr_resp;
  axil_resp_t rd_resp;
  axil_data_t rd_data;
  logic [6:0] status;

  // One outstanding response per channel
  assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
  assign rd_fire   = i_arvalid && !o_rvalid;
  assign o_awready = wr_fire;
  assign o_wready  = wr_fire;
  assign o_arready = rd_fire;

  // Command and data strobes last one cycle
  assign ctrl_wr     = wr_fire && (i_awaddr == REG_CTRL);
  assign o_send      = ctrl_wr && i_wdata[CTRL_SEND];
  assign o_clear_irq = ctrl_wr && i_wdata[CTRL_CLEAR_IRQ];
  assign o_txf_clear = ctrl_wr && i_wdata[CTRL_TXF_CLEAR];
  assign o_rxf_clear = ctrl_wr && i_wdata[CTRL_RXF_CLEAR];
  assign o_txf_push  = wr_fire && (i_awaddr == REG_TX_DATA) && !i_txf_full;
  assign o_txf_data  = i_wdata[7:0];
  assign o_rxf_pop   = rd_fire && (i_araddr == REG_RX_DATA) && !i_rxf_empty;

  assign status = {i_tx_busy, i_rxf_full, i_rxf_empty, i_txf_full, i_txf_empty,
                   i_tx_irq, i_rx_irq};

  always_comb begin
    case (i_awaddr)
      REG_LOCAL_IP, REG_SEND_IP, REG_SEND_PORTS, REG_SEND_LEN,
      REG_CTRL, REG_STATUS, REG_TX_DATA, REG_RX_DATA,
      REG_RECV_IP, REG_RECV_PORTS, REG_RECV_LEN: wr_resp = RESP_OKAY;
      default:                                    wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (i_araddr)
      REG_LOCAL_IP:   rd_data = o_local_ip;
      REG_SEND_IP:    rd_data = o_send_ip;
      REG_SEND_PORTS: rd_data = {o_send_src_port, o_send_dst_port};
      REG_SEND_LEN:   rd_data = axil_data_t'(o_send_len);
      REG_STATUS:     rd_data = axil_data_t'(status);
      REG_RX_DATA: begin
        if (!i_rxf_empty) rd_data = axil_data_t'(i_rxf_data);
      end
      REG_RECV_IP:    rd_data = i_recv_ip;
      REG_RECV_PORTS: rd_data = {i_recv_src_port, i_recv_dst_port};
      REG_RECV_LEN:   rd_data = axil_data_t'(i_recv_len);
      // Write-only registers read as zero
      REG_CTRL, REG_TX_DATA: rd_data = '0;
      default:        rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_local_ip      <= '0;
      o_send_ip       <= '0;
      o_send_src_port <= '0;
      o_send_dst_port <= '0;
      o_send_len      <= '0;
    end else if (wr_fire) begin
      case (i_awaddr)
        REG_LOCAL_IP: o_local_ip <= i_wdata;
        REG_SEND_IP:  o_send_ip  <= i_wdata;
        REG_SEND_PORTS: begin
          o_send_src_port <= i_wdata[31:16];
          o_send_dst_port <= i_wdata[15:0];
        end
        REG_SEND_LEN: o_send_len <= i_wdata[15:0];
        default: ;
      endcase
    end
  end

  // Write response
  always_ff @(posedge clk) begin
    if (rst) begin
      o_bvalid <= 1'b0;
    end else if (wr_fire) begin
      o_bvalid <= 1'b1;
    end else if (i_bready) begin
      o_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) o_bresp <= wr_resp;
  end

  // Read response
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rvalid <= 1'b0;
    end else if (rd_fire) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      o_rdata <= rd_data;
      o_rresp <= rd_resp;
    end
  end

endmodule

`default_nettype wire

// File: hdl/udp_host_if.sv
// UDP offload host controller
`timescale 1ns/1ps
`default_nettype none

module udp_host_if (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_awvalid,
  input  wire udp_host_pkg::axil_addr_t  i_awaddr,
  output logic                           o_awready,
  input  wire                            i_wvalid,
  input  wire udp_host_pkg::axil_data_t  i_wdata,
  output logic                           o_wready,
  output logic                           o_bvalid,
  output udp_host_pkg::axil_resp_t       o_bresp,
  input  wire                            i_bready,
  input  wire                            i_arvalid,
  input  wire udp_host_pkg::axil_addr_t  i_araddr,
  output logic                           o_arready,
  output logic                           o_rvalid,
  output udp_host_pkg::axil_data_t       o_rdata,
  output udp_host_pkg::axil_resp_t       o_rresp,
  input  wire                            i_rready,
  output logic                           o_tx_hdr_valid,
  output udp_host_pkg::ip_addr_t         o_tx_src_ip,
  output udp_host_pkg::ip_addr_t         o_tx_dst_ip,
  output udp_host_pkg::udp_port_t        o_tx_src_port,
  output udp_host_pkg::udp_port_t        o_tx_dst_port,
  output udp_host_pkg::udp_len_t         o_tx_udp_length,
  input  wire                            i_tx_hdr_ready,
  output udp_host_pkg::byte_t            o_tx_tdata,
  output logic                           o_tx_tvalid,
  output logic                           o_tx_tlast,
  input  wire                            i_tx_tready,
  input  wire                            i_rx_hdr_valid,
  input  wire udp_host_pkg::ip_addr_t    i_rx_src_ip,
  input  wire udp_host_pkg::udp_port_t   i_rx_src_port,
  input  wire udp_host_pkg::udp_port_t   i_rx_dst_port,
  input  wire udp_host_pkg::udp_len_t    i_rx_udp_length,
  input  wire udp_host_pkg::byte_t       i_rx_tdata,
  input  wire                            i_rx_tvalid,
  input  wire                            i_rx_tlast,
  output logic                           o_rx_tready,
  output logic                           o_irq_rx,
  output logic                           o_irq_tx
);
  import udp_host_pkg::*;

  udp_len_t  send_len;
  logic      send, clear_irq, tx_busy;
  logic      txf_clear, txf_push, txf_pop, txf_empty, txf_full;
  logic      rxf_clear, rxf_pop, rxf_empty, rxf_full;
  byte_t     txf_data, rxf_data;
  ip_addr_t  recv_ip;
  udp_port_t recv_src_port, recv_dst_port;
  udp_len_t  recv_len;

  // Inbound payload stalls only on a full FIFO
  assign o_rx_tready = !rxf_full;

  udp_csr u_csr (
    .clk, .rst, .i_awvalid, .i_awaddr, .o_awready, .i_wvalid, .i_wdata, .o_wready,
    .o_bvalid, .o_bresp, .i_bready, .i_arvalid, .i_araddr, .o_arready,
    .o_rvalid, .o_rdata, .o_rresp, .i_rready,
    .i_rx_irq (o_irq_rx), .i_tx_irq (o_irq_tx), .i_tx_busy (tx_busy),
    .i_txf_empty (txf_empty), .i_txf_full (txf_full),
    .i_rxf_empty (rxf_empty), .i_rxf_full (rxf_full), .i_rxf_data (rxf_data),
    .i_recv_ip (recv_ip), .i_recv_src_port (recv_src_port),
    .i_recv_dst_port (recv_dst_port), .i_recv_len (recv_len),
    .o_local_ip (o_tx_src_ip), .o_send_ip (o_tx_dst_ip),
    .o_send_src_port (o_tx_src_port), .o_send_dst_port (o_tx_dst_port),
    .o_send_len (send_len), .o_send (send), .o_clear_irq (clear_irq),
    .o_txf_clear (txf_clear), .o_rxf_clear (rxf_clear),
    .o_txf_push (txf_push), .o_rxf_pop (rxf_pop), .o_txf_data (txf_data)
  );

  pkt_fifo u_tx_fifo (
    .clk, .rst, .i_clear (txf_clear), .i_push (txf_push), .i_data (txf_data),
    .i_pop (txf_pop), .o_data (o_tx_tdata), .o_empty (txf_empty),
    .o_full (txf_full), .o_count ()
  );

  pkt_fifo u_rx_fifo (
    .clk, .rst, .i_clear (rxf_clear), .i_push (i_rx_tvalid), .i_data (i_rx_tdata),
    .i_pop (rxf_pop), .o_data (rxf_data), .o_empty (rxf_empty),
    .o_full (rxf_full), .o_count ()
  );

  udp_pkt_ctrl u_ctrl (
    .clk, .rst, .i_send (send), .i_clear_irq (clear_irq), .i_send_len (send_len),
    .o_tx_hdr_valid, .o_tx_udp_length, .o_tx_tvalid, .o_tx_tlast,
    .o_txf_pop (txf_pop), .o_tx_busy (tx_busy), .i_tx_hdr_ready,
    .i_txf_empty (txf_empty), .i_tx_tready,
    .i_rx_hdr_valid, .i_rx_src_ip, .i_rx_src_port, .i_rx_dst_port, .i_rx_udp_length,
    .i_rx_tvalid, .i_rx_tready (o_rx_tready), .i_rx_tlast,
    .o_recv_ip (recv_ip), .o_recv_src_port (recv_src_port),
    .o_recv_dst_port (recv_dst_port), .o_recv_len (recv_len),
    .o_irq_rx, .o_irq_tx
  );

endmodule

`default_nettype wire

// File: test/udp_host_if_assert.sv
// Handshake assertions for the host controller
`timescale 1ns/1ps
`default_nettype none

module udp_host_if_assert (
  input wire                           clk,
  input wire                           rst,
  input wire                           o_tx_hdr_valid,
  input wire                           i_tx_hdr_ready,
  input wire udp_host_pkg::udp_len_t   o_tx_udp_length,
  input wire udp_host_pkg::ip_addr_t   o_tx_dst_ip,
  input wire                           o_tx_tvalid,
  input wire                           i_tx_tready,
  input wire udp_host_pkg::byte_t      o_tx_tdata,
  input wire                           o_tx_tlast,
  input wire                           o_awready,
  input wire                           o_arready,
  input wire                           o_bvalid,
  input wire                           o_rvalid
);

  hdr_hold: assert property (@(posedge clk) disable iff (rst)
    o_tx_hdr_valid && !i_tx_hdr_ready |=>
      o_tx_hdr_valid && $stable(o_tx_udp_length) && $stable(o_tx_dst_ip))
    else $error("outbound header changed while stalled");

  data_hold: assert property (@(posedge clk) disable iff (rst)
    o_tx_tvalid && !i_tx_tready |=>
      o_tx_tvalid && $stable(o_tx_tdata) && $stable(o_tx_tlast))
    else $error("outbound payload changed while stalled");

  // Responses only follow an accepted request
  bvalid_cause: assert property (@(posedge clk) disable iff (rst)
    $rose(o_bvalid) |-> $past(o_awready))
    else $error("write response without a write handshake");

  rvalid_cause: assert property (@(posedge clk) disable iff (rst)
    $rose(o_rvalid) |-> $past(o_arready))
    else $error("read response without a read handshake");

endmodule

bind udp_host_if udp_host_if_assert u_assert (
  .clk, .rst, .o_tx_hdr_valid, .i_tx_hdr_ready, .o_tx_udp_length, .o_tx_dst_ip,
  .o_tx_tvalid, .i_tx_tready, .o_tx_tdata, .o_tx_tlast,
  .o_awready, .o_arready, .o_bvalid, .o_rvalid
);

`default_nettype wire

// File: test/tb_udp_host_if.sv
// UDP host controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_udp_host_if;
  import udp_host_pkg::*;

  localparam int MAX_OPS     = 96;
  localparam int OP_CYCLES   = 120;
  localparam int OP_WR       = 0;
  localparam int OP_RD       = 1;
  localparam int OP_RX_FRAME = 2;
  localparam int OP_TX_CHECK = 3;

  localparam ip_addr_t   LOCAL_IP  = 32'hC0A8_0001;
  localparam ip_addr_t   SEND_IP   = 32'hC0A8_0002;
  localparam axil_data_t SEND_PORT = 32'h1F90_0035;
  localparam ip_addr_t   RX_IP     = 32'h0A00_0007;
  localparam udp_port_t  RX_SPORT  = 16'h1388;
  localparam udp_port_t  RX_DPORT  = 16'h1F90;

  logic clk = 1'b0;
  logic rst;
  logic i_awvalid;
  axil_addr_t i_awaddr;
  logic i_wvalid;
  axil_data_t i_wdata;
  logic i_bready;
  logic i_arvalid;
  axil_addr_t i_araddr;
  logic i_rready;
  logic i_tx_hdr_ready;
  logic i_tx_tready;
  logic i_rx_hdr_valid;
  ip_addr_t i_rx_src_ip;
  udp_port_t i_rx_src_port;
  udp_port_t i_rx_dst_port;
  udp_len_t i_rx_udp_length;
  byte_t i_rx_tdata;
  logic i_rx_tvalid;
  logic i_rx_tlast;
  logic o_awready, o_wready, o_bvalid, o_arready, o_rvalid;
  axil_resp_t o_bresp, o_rresp;
  axil_data_t o_rdata;
  logic o_tx_hdr_valid, o_tx_tvalid, o_tx_tlast, o_rx_tready, o_irq_rx, o_irq_tx;
  ip_addr_t o_tx_src_ip, o_tx_dst_ip;
  udp_port_t o_tx_src_port, o_tx_dst_port;
  udp_len_t o_tx_udp_length;
  byte_t o_tx_tdata;

  // Stimulus table
  string      op_name [MAX_OPS];
  int         op_kind [MAX_OPS];
  axil_addr_t op_addr [MAX_OPS];
  axil_data_t op_data [MAX_OPS];
  axil_data_t op_exp  [MAX_OPS];
  axil_resp_t op_resp [MAX_OPS];
  int         n_ops = 0;

  byte_t rx_src_q[$];
  byte_t tx_exp_q[$];
  byte_t tx_got_q[$];
  logic  tx_last_q[$];
  int    hdr_count = 0;
  ip_addr_t  hdr_src_ip, hdr_dst_ip;
  udp_port_t hdr_src_port, hdr_dst_port;
  udp_len_t  hdr_len;

  logic [31:0] lfsr_state = 32'd76013;
  int          cycles = 0;
  int          cycle_limit = 0;
  axil_resp_t  got_resp;
  axil_data_t  got_data;

  udp_host_if uut (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic byte_t lfsr_byte();
    byte_t b;
    b = '0;
    for (int k = 0; k < 8; k++) b = {b[6:0], lfsr_bit()};
    return b;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input axil_data_t exp, input axil_data_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_ip(input string name, input ip_addr_t exp, input ip_addr_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_port(input string name, input udp_port_t exp, input udp_port_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_len(input string name, input udp_len_t exp, input udp_len_t act);
    if (act !== exp) abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic add_op(input string name, input int kind, input axil_addr_t addr,
                        input axil_data_t data, input axil_data_t exp, input axil_resp_t resp);
    op_name[n_ops] = name;
    op_kind[n_ops] = kind;
    op_addr[n_ops] = addr;
    op_data[n_ops] = data;
    op_exp[n_ops]  = exp;
    op_resp[n_ops] = resp;
    n_ops++;
  endtask

  task automatic add_write(input string name, input axil_addr_t addr, input axil_data_t data,
                           input axil_resp_t resp);
    add_op(name, OP_WR, addr, data, '0, resp);
  endtask

  task automatic add_read(input string name, input axil_addr_t addr, input axil_data_t exp,
                          input axil_resp_t resp);
    add_op(name, OP_RD, addr, '0, exp, resp);
  endtask

  // Kept bytes are the ones the next send must deliver
  task automatic add_tx_bytes(input string name, input int n, input logic kept);
    byte_t b;
    for (int k = 0; k < n; k++) begin
      b = lfsr_byte();
      add_write(name, REG_TX_DATA, axil_data_t'(b), RESP_OKAY);
      if (kept) tx_exp_q.push_back(b);
    end
  endtask

  task automatic add_rx_frame(input string name, input int n);
    for (int k = 0; k < n; k++) rx_src_q.push_back(lfsr_byte());
    add_op(name, OP_RX_FRAME, '0, axil_data_t'(n), '0, RESP_OKAY);
  endtask

  task automatic build_table();
    add_read("status after reset", REG_STATUS, 32'h14, RESP_OKAY);
    add_write("local ip", REG_LOCAL_IP, LOCAL_IP, RESP_OKAY);
    add_write("send ip", REG_SEND_IP, SEND_IP, RESP_OKAY);
    add_write("send ports", REG_SEND_PORTS, SEND_PORT, RESP_OKAY);
    add_write("send len", REG_SEND_LEN, 32'h0000_1234, RESP_OKAY);
    add_read("local ip back", REG_LOCAL_IP, LOCAL_IP, RESP_OKAY);
    add_read("send ip back", REG_SEND_IP, SEND_IP, RESP_OKAY);
    add_read("send ports back", REG_SEND_PORTS, SEND_PORT, RESP_OKAY);
    add_read("send len back", REG_SEND_LEN, 32'h0000_1234, RESP_OKAY);
    add_write("unmapped write", 8'h30, 32'hFFFF_FFFF, RESP_SLVERR);
    add_read("unmapped read", 8'h30, '0, RESP_SLVERR);
    add_read("ctrl reads zero", REG_CTRL, '0, RESP_OKAY);
    add_write("status write ignored", REG_STATUS, 32'hFF, RESP_OKAY);
    add_read("status unchanged", REG_STATUS, 32'h14, RESP_OKAY);
    // Short send
    add_write("len 5", REG_SEND_LEN, 32'd5, RESP_OKAY);
    add_tx_bytes("tx push", 5, 1'b1);
    add_write("send 5", REG_CTRL, 32'h1, RESP_OKAY);
    add_op("tx frame 5", OP_TX_CHECK, '0, 32'd5, '0, RESP_OKAY);
    add_read("status after send", REG_STATUS, 32'h16, RESP_OKAY);
    // Inbound datagram
    add_rx_frame("rx frame 4", 4);
    add_read("recv ip", REG_RECV_IP, RX_IP, RESP_OKAY);
    add_read("recv ports", REG_RECV_PORTS, {RX_SPORT, RX_DPORT}, RESP_OKAY);
    add_read("recv len", REG_RECV_LEN, 32'd12, RESP_OKAY);
    add_read("status after rx", REG_STATUS, 32'h07, RESP_OKAY);
    for (int k = 0; k < 4; k++) begin
      add_read("rx byte", REG_RX_DATA, axil_data_t'(rx_src_q[k]), RESP_OKAY);
    end
    add_read("rx empty read", REG_RX_DATA, '0, RESP_OKAY);
    add_read("status rx drained", REG_STATUS, 32'h17, RESP_OKAY);
    // Clears
    add_write("clear irq", REG_CTRL, 32'h2, RESP_OKAY);
    add_read("status irq cleared", REG_STATUS, 32'h14, RESP_OKAY);
    add_tx_bytes("tx push dropped", 3, 1'b0);
    add_read("status tx loaded", REG_STATUS, 32'h10, RESP_OKAY);
    add_write("clear tx fifo", REG_CTRL, 32'h4, RESP_OKAY);
    add_read("status tx cleared", REG_STATUS, 32'h14, RESP_OKAY);
    add_rx_frame("rx frame 3", 3);
    add_read("status rx loaded", REG_STATUS, 32'h05, RESP_OKAY);
    add_write("clear rx fifo and irq", REG_CTRL, 32'hA, RESP_OKAY);
    add_read("status rx cleared", REG_STATUS, 32'h14, RESP_OKAY);
    // Full FIFO
    add_tx_bytes("tx fill", FIFO_DEPTH, 1'b1);
    add_read("status tx full", REG_STATUS, 32'h18, RESP_OKAY);
    add_tx_bytes("tx overflow", 1, 1'b0);
    add_write("len 16", REG_SEND_LEN, axil_data_t'(FIFO_DEPTH), RESP_OKAY);
    add_write("send 16", REG_CTRL, 32'h1, RESP_OKAY);
    add_op("tx frame 16", OP_TX_CHECK, '0, axil_data_t'(FIFO_DEPTH), '0, RESP_OKAY);
    add_read("status after full send", REG_STATUS, 32'h16, RESP_OKAY);
  endtask

  task automatic csr_write(input axil_addr_t addr, input axil_data_t data,
                           output axil_resp_t resp);
    @(negedge clk);
    i_awvalid = 1'b1;
    i_awaddr  = addr;
    i_wvalid  = 1'b1;
    i_wdata   = data;
    @(posedge clk);
    while (!o_awready) @(posedge clk);
    if (!o_wready) abort_run("Write data was not accepted together with its address");
    @(negedge clk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    while (!o_bvalid) @(negedge clk);
    resp = o_bresp;
  endtask

  task automatic csr_read(input axil_addr_t addr, output axil_data_t data,
                          output axil_resp_t resp);
    @(negedge clk);
    i_arvalid = 1'b1;
    i_araddr  = addr;
    @(posedge clk);
    while (!o_arready) @(posedge clk);
    @(negedge clk);
    i_arvalid = 1'b0;
    while (!o_rvalid) @(negedge clk);
    data = o_rdata;
    resp = o_rresp;
  endtask

  // Inbound stack model
  task automatic send_rx_frame(input int n);
    @(negedge clk);
    i_rx_hdr_valid  = 1'b1;
    i_rx_src_ip     = RX_IP;
    i_rx_src_port   = RX_SPORT;
    i_rx_dst_port   = RX_DPORT;
    i_rx_udp_length = udp_len_t'(n + 8);
    @(negedge clk);
    i_rx_hdr_valid = 1'b0;
    for (int k = 0; k < n; k++) begin
      i_rx_tdata  = rx_src_q.pop_front();
      i_rx_tvalid = 1'b1;
      i_rx_tlast  = (k == n - 1);
      @(posedge clk);
      while (!o_rx_tready) @(posedge clk);
      @(negedge clk);
    end
    i_rx_tvalid = 1'b0;
    i_rx_tlast  = 1'b0;
  endtask

  task automatic check_tx_frame(input string name, input int n);
    while (tx_got_q.size() < n || !o_irq_tx) @(negedge clk);
    if (hdr_count != 1) abort_run($sformatf("%s saw %0d outbound headers", name, hdr_count));
    if (tx_got_q.size() != n) abort_run($sformatf("%s got too many payload bytes", name));
    check_ip({name, " src ip"}, LOCAL_IP, hdr_src_ip);
    check_ip({name, " dst ip"}, SEND_IP, hdr_dst_ip);
    check_port({name, " src port"}, SEND_PORT[31:16], hdr_src_port);
    check_port({name, " dst port"}, SEND_PORT[15:0], hdr_dst_port);
    check_len({name, " udp length"}, udp_len_t'(n + 8), hdr_len);
    for (int k = 0; k < n; k++) begin
      check_byte({name, " payload"}, tx_exp_q.pop_front(), tx_got_q[k]);
      if (tx_last_q[k] !== (k == n - 1)) begin
        abort_run($sformatf("%s tlast wrong on byte %0d", name, k));
      end
    end
    tx_got_q.delete();
    tx_last_q.delete();
    hdr_count = 0;
  endtask

  // Outbound stack model with random ready gaps
  always @(negedge clk) begin
    i_tx_tready    = lfsr_bit();
    i_tx_hdr_ready = lfsr_bit();
  end

  always @(posedge clk) begin
    if (!rst && o_tx_hdr_valid && i_tx_hdr_ready) begin
      hdr_count++;
      hdr_src_ip   = o_tx_src_ip;
      hdr_dst_ip   = o_tx_dst_ip;
      hdr_src_port = o_tx_src_port;
      hdr_dst_port = o_tx_dst_port;
      hdr_len      = o_tx_udp_length;
    end
    if (!rst && o_tx_tvalid && i_tx_tready) begin
      tx_got_q.push_back(o_tx_tdata);
      tx_last_q.push_back(o_tx_tlast);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) abort_run("Timeout: the tests did not finish in time");
  end

  initial begin
    rst = 1'b1;
    i_awvalid = 1'b0;
    i_awaddr = '0;
    i_wvalid = 1'b0;
    i_wdata = '0;
    i_bready = 1'b1;
    i_arvalid = 1'b0;
    i_araddr = '0;
    i_rready = 1'b1;
    i_tx_hdr_ready = 1'b0;
    i_tx_tready = 1'b0;
    i_rx_hdr_valid = 1'b0;
    i_rx_src_ip = '0;
    i_rx_src_port = '0;
    i_rx_dst_port = '0;
    i_rx_udp_length = '0;
    i_rx_tdata = '0;
    i_rx_tvalid = 1'b0;
    i_rx_tlast = 1'b0;
    build_table();
    cycle_limit = n_ops * OP_CYCLES + 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      case (op_kind[i])
        OP_WR: begin
          csr_write(op_addr[i], op_data[i], got_resp);
          check_resp(op_name[i], op_resp[i], got_resp);
        end
        OP_RD: begin
          csr_read(op_addr[i], got_data, got_resp);
          check_resp(op_name[i], op_resp[i], got_resp);
          check_data(op_name[i], op_exp[i], got_data);
          // Interrupt lines follow the two low status bits
          if (op_addr[i] == REG_STATUS) begin
            check_data({op_name[i], " irq lines"}, op_exp[i] & 32'h3,
                       axil_data_t'({o_irq_tx, o_irq_rx}));
          end
        end
        OP_RX_FRAME: send_rx_frame(int'(op_data[i]));
        default: check_tx_frame(op_name[i], int'(op_data[i]));
      endcase
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: udp_host_if.f
hdl/udp_host_pkg.sv
hdl/pkt_fifo.sv
hdl/udp_pkt_ctrl.sv
hdl/udp_csr.sv
hdl/udp_host_if.sv
test/udp_host_if_assert.sv
test/tb_udp_host_if.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_udp_host_if
FLIST     := udp_host_if.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
